// ==== hdl/rm_defines.svh ====
`ifndef RM_DEFINES_SVH
`define RM_DEFINES_SVH

// width of a memory bus address
`define RM_ADDR_W 32

// width of a data word on the bus and in the register
`define RM_DATA_W 32

// register number field in the operand selection
`define RM_REG_NUM_W 4

`endif

// ==== hdl/rm_cpu_pkg.sv ====
`default_nettype none

`include "rm_defines.svh"

package rm_cpu_pkg;

  // scalar aliases for bus address and data word
  typedef logic [`RM_ADDR_W-1:0] addr_t;
  typedef logic [`RM_DATA_W-1:0] data_t;

  // register ops held by the core until next_state
  typedef enum logic [2:0] {
    op_idle    = 3'd0,
    op_catch   = 3'd1,
    op_read    = 3'd2,
    op_read_p  = 3'd3,
    op_write   = 3'd4,
    op_write_p = 3'd5
  } reg_op_t;

  // processor cycle state
  // only alu_results changes what catch takes
  typedef enum logic [1:0] {
    st_fetch       = 2'd0,
    st_decode      = 2'd1,
    st_operand     = 2'd2,
    st_alu_results = 2'd3
  } cpu_state_t;

  // post-adjust applied to a plain write
  typedef enum logic [1:0] {
    flags_none = 2'b00,
    flags_inc  = 2'b01,
    flags_dec  = 2'b10
  } reg_flags_t;

  // operand selection from the decoder, 7 bits
  typedef struct packed {
    logic [`RM_REG_NUM_W-1:0] reg_num;
    logic                     is_ptr;
    reg_flags_t               flags;
  } reg_sel_t;

  // process memory map, 128 bits
  typedef struct packed {
    addr_t base_code;
    addr_t base_data;
    addr_t mem1_size;
    addr_t unmod_bound;
  } mem_map_t;

endpackage

`default_nettype wire

// ==== hdl/rm_bus_pkg.sv ====
`default_nettype none

package rm_bus_pkg;

  // request from the manager to the shared memory bus
  // addr and data are zero while no strobe is up
  typedef struct packed {
    logic              read_q;
    logic              write_q;
    rm_cpu_pkg::addr_t addr;
    rm_cpu_pkg::data_t data;
  } bus_req_t;

  // response from the bus
  // one-cycle done pulse, addr echoes the request
  // data only meaningful with read_dn
  typedef struct packed {
    logic              read_dn;
    logic              write_dn;
    rm_cpu_pkg::addr_t addr;
    rm_cpu_pkg::data_t data;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/addr_translator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rm_defines.svh"

module addr_translator (
  input  wire rm_cpu_pkg::reg_sel_t sel,
  input  wire rm_cpu_pkg::mem_map_t map,
  input  wire rm_cpu_pkg::data_t    ptr,
  output rm_cpu_pkg::addr_t         reg_addr,
  output rm_cpu_pkg::addr_t         ptr_addr,
  output rm_cpu_pkg::addr_t         num_addr
);

  // register number widened to a bus address
  rm_cpu_pkg::addr_t num_raw;

  // three-region map of a raw address
  function automatic rm_cpu_pkg::addr_t translate(input rm_cpu_pkg::addr_t raw,
                                                  input rm_cpu_pkg::mem_map_t mm);
    rm_cpu_pkg::addr_t base;
    // above the bound the address is absolute
    if (raw >= mm.unmod_bound) begin
      base = '0;
    end else if (raw >= mm.mem1_size) begin
      base = mm.base_data;
    end else begin
      base = mm.base_code;
    end
    return raw + base;
  endfunction

  assign num_raw = {{(`RM_ADDR_W-`RM_REG_NUM_W){1'b0}}, sel.reg_num};

  // register slot in the code segment, no region check
  assign reg_addr = map.base_code + num_raw;
  // pointer as raw address
  assign ptr_addr = translate(ptr, map);
  assign num_addr = translate(num_raw, map);

  // data region must start below the absolute region
  always_comb begin
    mem_map_order_a: assert #0 (map.mem1_size <= map.unmod_bound);
  end

endmodule

`default_nettype wire

// ==== hdl/reg_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_datapath (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire rm_cpu_pkg::cpu_state_t state,
  input  wire rm_cpu_pkg::reg_sel_t   sel,
  input  wire rm_cpu_pkg::data_t      register_in,
  input  wire rm_cpu_pkg::data_t      reg_ptr_in,
  input  wire logic                   load_catch,
  input  wire logic                   load_read,
  input  wire logic                   load_read_p,
  input  wire rm_cpu_pkg::data_t      bus_data,
  output rm_cpu_pkg::data_t           register_out,
  output rm_cpu_pkg::data_t           reg_ptr_out,
  output rm_cpu_pkg::data_t           store_direct,
  output rm_cpu_pkg::data_t           store_ptr
);

  // register value and pointer value
  rm_cpu_pkg::data_t reg_q;
  rm_cpu_pkg::data_t ptr_q;

  // plain-write value before the post-adjust
  rm_cpu_pkg::data_t direct_raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_q <= '0;
      ptr_q <= '0;
    end else begin
      if (load_catch) begin
        // alu result goes to the register only
        if (state == rm_cpu_pkg::st_alu_results) begin
          reg_q <= register_in;
        end else begin
          // otherwise pointer path feeds both
          reg_q <= reg_ptr_in;
          ptr_q <= reg_ptr_in;
        end
      end
      // fetched word is both value and pointer
      if (load_read) begin
        reg_q <= bus_data;
        ptr_q <= bus_data;
      end
      // fetch through pointer keeps the pointer
      if (load_read_p) begin
        reg_q <= bus_data;
      end
    end
  end

  // write through pointer, never adjusted
  assign store_ptr = sel.is_ptr ? reg_q : ptr_q;

  // plain write picks the opposite value
  assign direct_raw = sel.is_ptr ? ptr_q : reg_q;

  always_comb begin
    case (sel.flags)
      // post increment
      rm_cpu_pkg::flags_inc: store_direct = direct_raw + 1'b1;
      // post decrement
      rm_cpu_pkg::flags_dec: store_direct = direct_raw - 1'b1;
      default:               store_direct = direct_raw;
    endcase
  end

  assign register_out = reg_q;
  assign reg_ptr_out  = ptr_q;

  // sequencer issues one load command per cycle at most
  load_onehot_a: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({load_catch, load_read, load_read_p})
  );

endmodule

`default_nettype wire

// ==== hdl/bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire rm_cpu_pkg::reg_op_t  op,
  input  wire rm_cpu_pkg::addr_t    reg_addr,
  input  wire rm_cpu_pkg::addr_t    ptr_addr,
  input  wire rm_cpu_pkg::addr_t    num_addr,
  input  wire rm_cpu_pkg::data_t    store_direct,
  input  wire rm_cpu_pkg::data_t    store_ptr,
  input  wire rm_bus_pkg::bus_rsp_t bus_rsp,
  output rm_bus_pkg::bus_req_t      bus_req,
  output logic                      load_catch,
  output logic                      load_read,
  output logic                      load_read_p,
  output logic                      next_state
);

  // armed by idle, spent by the first action of an op
  logic armed_q;
  // request strobe gone, waiting for done
  logic wait_q;
  logic next_q;
  // address the matching done must carry
  rm_cpu_pkg::addr_t pend_q;
  // registered bus request
  rm_bus_pkg::bus_req_t req_q;

  // op decode
  logic is_read_op;
  logic is_write_op;
  logic issue;
  logic rsp_hit;
  rm_cpu_pkg::addr_t issue_addr;
  rm_cpu_pkg::data_t issue_data;

  always_comb begin
    is_read_op  = (op == rm_cpu_pkg::op_read) || (op == rm_cpu_pkg::op_read_p);
    is_write_op = (op == rm_cpu_pkg::op_write) || (op == rm_cpu_pkg::op_write_p);
    // reads carry no data
    issue_data  = '0;
    case (op)
      rm_cpu_pkg::op_read: begin
        issue_addr = reg_addr;
      end
      rm_cpu_pkg::op_read_p: begin
        issue_addr = ptr_addr;
      end
      rm_cpu_pkg::op_write: begin
        issue_addr = num_addr;
        issue_data = store_direct;
      end
      rm_cpu_pkg::op_write_p: begin
        issue_addr = ptr_addr;
        issue_data = store_ptr;
      end
      default: begin
        issue_addr = '0;
      end
    endcase
  end

  // one request per armed bus op
  assign issue = armed_q && (is_read_op || is_write_op);

  // done must fit the op and echo the pending address
  // stray responses fall through here
  assign rsp_hit = wait_q && (bus_rsp.addr == pend_q) &&
                   ((is_read_op && bus_rsp.read_dn) || (is_write_op && bus_rsp.write_dn));

  // catch loads on the edge that samples it
  assign load_catch  = armed_q && (op == rm_cpu_pkg::op_catch);
  assign load_read   = rsp_hit && (op == rm_cpu_pkg::op_read);
  assign load_read_p = rsp_hit && (op == rm_cpu_pkg::op_read_p);

  always_ff @(posedge clk) begin
    if (rst) begin
      // ready for the first op out of reset
      armed_q <= 1'b1;
      wait_q  <= 1'b0;
      next_q  <= 1'b0;
      req_q   <= '0;
    end else begin
      next_q <= 1'b0;
      // idle between ops re-arms
      if (op == rm_cpu_pkg::op_idle) begin
        armed_q <= 1'b1;
      end
      if (load_catch) begin
        armed_q <= 1'b0;
        next_q  <= 1'b1;
      end
      if (issue) begin
        armed_q       <= 1'b0;
        req_q.read_q  <= is_read_op;
        req_q.write_q <= is_write_op;
        req_q.addr    <= issue_addr;
        req_q.data    <= issue_data;
      end else if (req_q.read_q || req_q.write_q) begin
        // strobe lasts one cycle, then wait for done
        req_q  <= '0;
        wait_q <= 1'b1;
      end
      // bus latency ends here
      if (rsp_hit) begin
        wait_q <= 1'b0;
        next_q <= 1'b1;
      end
    end
  end

  // pending address latched with the request
  always_ff @(posedge clk) begin
    if (issue) begin
      pend_q <= issue_addr;
    end
  end

  assign bus_req    = req_q;
  assign next_state = next_q;

  // read and write never on the bus together
  strobe_excl_a: assert property (
    @(posedge clk) disable iff (rst)
    !(bus_req.read_q && bus_req.write_q)
  );

  read_pulse_a: assert property (
    @(posedge clk) disable iff (rst)
    bus_req.read_q |=> !bus_req.read_q
  );

  write_pulse_a: assert property (
    @(posedge clk) disable iff (rst)
    bus_req.write_q |=> !bus_req.write_q
  );

  // core sees a single completion per op
  next_pulse_a: assert property (
    @(posedge clk) disable iff (rst)
    next_state |=> !next_state
  );

endmodule

`default_nettype wire

// ==== hdl/register_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_manager (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire rm_cpu_pkg::reg_op_t    op,
  input  wire rm_cpu_pkg::cpu_state_t state,
  input  wire rm_cpu_pkg::reg_sel_t   sel,
  input  wire rm_cpu_pkg::mem_map_t   map,
  input  wire rm_cpu_pkg::data_t      register_in,
  input  wire rm_cpu_pkg::data_t      reg_ptr_in,
  output rm_cpu_pkg::data_t           register_out,
  output rm_cpu_pkg::data_t           reg_ptr_out,
  output rm_bus_pkg::bus_req_t        bus_req,
  input  wire rm_bus_pkg::bus_rsp_t   bus_rsp,
  output logic                        next_state
);

  // translated addresses
  rm_cpu_pkg::addr_t reg_addr;
  rm_cpu_pkg::addr_t ptr_addr;
  rm_cpu_pkg::addr_t num_addr;

  // candidate store values
  rm_cpu_pkg::data_t store_direct;
  rm_cpu_pkg::data_t store_ptr;

  // load commands from the sequencer
  logic load_catch;
  logic load_read;
  logic load_read_p;

  // pointer value feeds translation back from the datapath
  addr_translator addr_translator_i (
    .sel      (sel),
    .map      (map),
    .ptr      (reg_ptr_out),
    .reg_addr (reg_addr),
    .ptr_addr (ptr_addr),
    .num_addr (num_addr)
  );

  // bus word goes straight to the datapath
  reg_datapath reg_datapath_i (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .sel          (sel),
    .register_in  (register_in),
    .reg_ptr_in   (reg_ptr_in),
    .load_catch   (load_catch),
    .load_read    (load_read),
    .load_read_p  (load_read_p),
    .bus_data     (bus_rsp.data),
    .register_out (register_out),
    .reg_ptr_out  (reg_ptr_out),
    .store_direct (store_direct),
    .store_ptr    (store_ptr)
  );

  bus_sequencer bus_sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .reg_addr     (reg_addr),
    .ptr_addr     (ptr_addr),
    .num_addr     (num_addr),
    .store_direct (store_direct),
    .store_ptr    (store_ptr),
    .bus_rsp      (bus_rsp),
    .bus_req      (bus_req),
    .load_catch   (load_catch),
    .load_read    (load_read),
    .load_read_p  (load_read_p),
    .next_state   (next_state)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_bus_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bus_responder (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire rm_bus_pkg::bus_req_t bus_req,
  input  wire logic [2:0]           rsp_delay,
  input  wire logic                 rsp_stray,
  output rm_bus_pkg::bus_rsp_t      bus_rsp,
  output int unsigned               match_cnt
);

  // sparse memory, unwritten words come from fill_word
  rm_cpu_pkg::data_t mem [rm_cpu_pkg::addr_t];

  rm_bus_pkg::bus_rsp_t rsp_q = '0;
  int unsigned          match_q = 0;
  logic                 busy_q = 1'b0;
  logic                 is_read_q;
  logic                 stray_q;
  logic [2:0]           wait_q;
  rm_cpu_pkg::addr_t    addr_q;

  // every address bit reaches the word
  function automatic rm_cpu_pkg::data_t fill_word(input rm_cpu_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
  endfunction

  function automatic rm_cpu_pkg::data_t read_word(input rm_cpu_pkg::addr_t a);
    if (mem.exists(a)) return mem[a];
    return fill_word(a);
  endfunction

  // request seen on one falling edge, done no earlier than the next
  always @(negedge clk) begin
    rm_bus_pkg::bus_rsp_t nxt;
    nxt = '0;
    if (rst) begin
      busy_q = 1'b0;
    end else if (busy_q) begin
      if (stray_q) begin
        // right done type, neighbouring address
        nxt.read_dn  = is_read_q;
        nxt.write_dn = !is_read_q;
        nxt.addr     = addr_q ^ 32'h1;
        nxt.data     = is_read_q ? ~read_word(addr_q) : '0;
        stray_q      = 1'b0;
      end else if (wait_q != 3'd0) begin
        wait_q = wait_q - 3'd1;
      end else begin
        nxt.read_dn  = is_read_q;
        nxt.write_dn = !is_read_q;
        nxt.addr     = addr_q;
        nxt.data     = is_read_q ? read_word(addr_q) : '0;
        match_q      = match_q + 1;
        busy_q       = 1'b0;
      end
    end else if (bus_req.read_q || bus_req.write_q) begin
      busy_q    = 1'b1;
      is_read_q = bus_req.read_q;
      addr_q    = bus_req.addr;
      wait_q    = rsp_delay;
      stray_q   = rsp_stray;
      if (bus_req.write_q) mem[bus_req.addr] = bus_req.data;
    end
    rsp_q = nxt;
  end

  assign bus_rsp   = rsp_q;
  assign match_cnt = match_q;

endmodule

`default_nettype wire

// ==== testbench/tb_register_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_register_manager;

  localparam int CLK_PERIOD = 100;
  localparam int N_OPS      = 200;
  // longest op is a stray done plus delay 7
  localparam int OP_CYCLES  = 20;

  // 3 random bits pick catch or one of the read and write flavours
  localparam rm_cpu_pkg::reg_op_t OP_TAB [8] = '{
    rm_cpu_pkg::op_catch, rm_cpu_pkg::op_catch, rm_cpu_pkg::op_read, rm_cpu_pkg::op_read_p,
    rm_cpu_pkg::op_write, rm_cpu_pkg::op_write_p, rm_cpu_pkg::op_read_p, rm_cpu_pkg::op_write_p
  };

  logic                   clk;
  logic                   rst;
  rm_cpu_pkg::reg_op_t    op;
  rm_cpu_pkg::cpu_state_t state;
  rm_cpu_pkg::reg_sel_t   sel;
  rm_cpu_pkg::mem_map_t   map;
  rm_cpu_pkg::data_t      register_in;
  rm_cpu_pkg::data_t      reg_ptr_in;
  rm_cpu_pkg::data_t      register_out;
  rm_cpu_pkg::data_t      reg_ptr_out;
  rm_bus_pkg::bus_req_t   bus_req;
  rm_bus_pkg::bus_rsp_t   bus_rsp;
  logic                   next_state;
  // responder knobs and its count of matching dones
  logic [2:0]             rsp_delay;
  logic                   rsp_stray;
  int unsigned            match_cnt;

  // model state and mirror memory
  rm_cpu_pkg::data_t m_reg;
  rm_cpu_pkg::data_t m_ptr;
  rm_cpu_pkg::data_t mirror [rm_cpu_pkg::addr_t];
  logic [15:0]       lfsr_q;

  register_manager dut_i (.*);
  tb_bus_responder resp_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(N_OPS * OP_CYCLES * CLK_PERIOD);
    $display("timeout: DUT hung, run did not finish within %0d ns",
             N_OPS * OP_CYCLES * CLK_PERIOD);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  // taps 16 14 13 11 with one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      v      = {v[30:0], lfsr_q[15]};
      lfsr_q = {lfsr_q[14:0], fb};
    end
    return v;
  endfunction

  // initial memory content follows the responder fill rule
  function automatic rm_cpu_pkg::data_t fill_word(input rm_cpu_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
  endfunction

  // absolute, data and code regions
  function automatic rm_cpu_pkg::addr_t map_addr(input rm_cpu_pkg::addr_t raw);
    if (raw >= map.unmod_bound) return raw;
    if (raw >= map.mem1_size) return raw + map.base_data;
    return raw + map.base_code;
  endfunction

  task automatic report_failure(input string what);
    $display("error: %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_data(input string name, input rm_cpu_pkg::data_t want,
                            input rm_cpu_pkg::data_t got);
    if (got !== want) begin
      $display("** Error %s: expected %h, actual %h", name, want, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_addr(input string name, input rm_cpu_pkg::addr_t want,
                            input rm_cpu_pkg::addr_t got);
    if (got !== want) begin
      $display("** Error %s: expected %h, actual %h", name, want, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_req(input string name, input rm_bus_pkg::bus_req_t want,
                           input rm_bus_pkg::bus_req_t got);
    if (got !== want) begin
      $display("** Error %s: expected %h, actual %h", name, want, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "request mismatch");
    end
  endtask

  // one op through the DUT and one idle cycle after it
  task automatic run_op(input rm_cpu_pkg::reg_op_t op_v);
    rm_bus_pkg::bus_req_t want;
    rm_cpu_pkg::data_t    new_reg;
    rm_cpu_pkg::data_t    new_ptr;
    string                name;
    int unsigned          done_before;
    int                   cycles;
    int                   strobes;
    want    = '0;
    new_reg = m_reg;
    new_ptr = m_ptr;
    name    = op_v.name();
    case (op_v)
      rm_cpu_pkg::op_catch: begin
        new_reg = (state == rm_cpu_pkg::st_alu_results) ? register_in : reg_ptr_in;
        if (state != rm_cpu_pkg::st_alu_results) new_ptr = reg_ptr_in;
      end
      rm_cpu_pkg::op_read, rm_cpu_pkg::op_read_p: begin
        want.read_q = 1'b1;
        // plain read goes to the code-base slot
        want.addr = (op_v == rm_cpu_pkg::op_read) ?
                    map.base_code + rm_cpu_pkg::addr_t'(sel.reg_num) : map_addr(m_ptr);
        new_reg = mirror.exists(want.addr) ? mirror[want.addr] : fill_word(want.addr);
        if (op_v == rm_cpu_pkg::op_read) new_ptr = new_reg;
      end
      rm_cpu_pkg::op_write: begin
        want.write_q = 1'b1;
        want.addr    = map_addr(rm_cpu_pkg::addr_t'(sel.reg_num));
        want.data    = sel.is_ptr ? m_ptr : m_reg;
        if (sel.flags == rm_cpu_pkg::flags_inc) want.data = want.data + 32'd1;
        if (sel.flags == rm_cpu_pkg::flags_dec) want.data = want.data - 32'd1;
      end
      rm_cpu_pkg::op_write_p: begin
        want.write_q = 1'b1;
        want.addr    = map_addr(m_ptr);
        want.data    = sel.is_ptr ? m_reg : m_ptr;
      end
      default: ;
    endcase
    done_before = match_cnt;
    cycles      = 0;
    strobes     = 0;
    op          = op_v;
    while (!next_state) begin
      @(negedge clk);
      cycles++;
      if (bus_req.read_q || bus_req.write_q) begin
        strobes++;
        if (!(want.read_q || want.write_q) || strobes > 1 || cycles != 1)
          report_failure($sformatf("%s: unexpected bus strobe in cycle %0d", name, cycles));
        check_addr({name, " request address"}, want.addr, bus_req.addr);
        check_req({name, " request"}, want, bus_req);
        if (want.write_q) mirror[want.addr] = want.data;
      end else begin
        check_req({name, " quiet bus"}, '0, bus_req);
      end
      // latency and stray dones load nothing
      if (!next_state) begin
        check_data({name, " register held"}, m_reg, register_out);
        check_data({name, " pointer held"}, m_ptr, reg_ptr_out);
      end
    end
    if (!(want.read_q || want.write_q) && cycles != 1)
      report_failure({name, ": catch did not finish in its first cycle"});
    if ((want.read_q || want.write_q) && (strobes != 1 || match_cnt != done_before + 1))
      report_failure({name, ": next_state without one request and its matching done"});
    m_reg = new_reg;
    m_ptr = new_ptr;
    check_data({name, " register_out"}, m_reg, register_out);
    check_data({name, " reg_ptr_out"}, m_ptr, reg_ptr_out);
    if (want.write_q) check_data({name, " memory"}, mirror[want.addr], resp_i.mem[want.addr]);
    op = rm_cpu_pkg::op_idle;
    @(negedge clk);
    if (next_state) report_failure({name, ": next_state high for more than one cycle"});
    check_req({name, " idle bus"}, '0, bus_req);
  endtask

  initial begin
    lfsr_q      = 16'd84;
    rst         = 1'b1;
    op          = rm_cpu_pkg::op_idle;
    state       = rm_cpu_pkg::st_fetch;
    sel         = '0;
    register_in = '0;
    reg_ptr_in  = '0;
    rsp_delay   = '0;
    rsp_stray   = 1'b0;
    map = '{base_code: 32'h0000_1000, base_data: 32'h0004_0000,
            mem1_size: 32'h0000_0100, unmod_bound: 32'h0001_0000};
    m_reg = '0;
    m_ptr = '0;
    // five reset edges, release on the falling edge after them
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_req("reset bus_req", '0, bus_req);
    check_data("reset register_out", '0, register_out);
    check_data("reset reg_ptr_out", '0, reg_ptr_out);
    if (next_state !== 1'b0) report_failure("next_state high right after reset");
    for (int n = 0; n < N_OPS; n++) begin
      state       = rm_cpu_pkg::cpu_state_t'(take_bits(2));
      sel         = 7'(take_bits(7));
      register_in = take_bits(32);
      // pointers in code, data and absolute regions
      case (take_bits(2))
        0: reg_ptr_in = take_bits(8);
        1: reg_ptr_in = map.mem1_size + take_bits(15);
        default: reg_ptr_in = take_bits(32);
      endcase
      rsp_delay = 3'(take_bits(3));
      rsp_stray = (take_bits(2) == 0);
      run_op(OP_TAB[3'(take_bits(3))]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/rm_cpu_pkg.sv
hdl/rm_bus_pkg.sv
hdl/addr_translator.sv
hdl/reg_datapath.sv
hdl/bus_sequencer.sv
hdl/register_manager.sv
testbench/tb_bus_responder.sv
testbench/tb_register_manager.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_register_manager -o tb_sim &&
./obj_dir/tb_sim | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
